// File: cpu_core.f
source/cpu_pkg.sv
source/reg_file.sv
source/stage_if.sv
source/stage_id.sv
source/stage_ex.sv
source/stage_mem.sv
source/cpu_core.sv
bench/cpu_core_tb.sv

// File: Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -j 0
TOP       ?= cpu_core_tb
FILELIST  ?= cpu_core.f
LOG       ?= sim.log
PASS_TEXT  = TEST RESULT: PASS

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim: build
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: bench/program_input.txt
// Program words in hex, four per line, ended by ffffffff
// Then expected retirements as pairs of register index and data, ended by ffffffff
123450b7 67808093 00001117 ffb00193 // lui x1, addi x1, auipc x2, addi x3
0011a213 0011b293 4011d313 01c1d393 // slti, sltiu, srai, srli
00409413 fff0c493 0f006513 0ff0f593 // slli, xori, ori, andi
00308633 401606b3 0041a733 003237b3 // add, sub, slt, sltu
00721833 4041d8b3 0041d933 0090c9b3 // sll, sra, srl, xor
00b56a33 00ba7ab3 00102023 009002a3 // or, and, sw, sb
00301323 00002b03 001b0b93 00500c03 // sh, lw, addi after load, lb
00504c83 00601d03 00605d83 01ad8e33 // lbu, lh, lhu, add after load
00d18663 00100e93 00200e93 00d19663 // beq taken, two skipped, bne falls through
0041c663 00300e93 00400e93 0041e663 // blt taken, two skipped, bltu falls through
0041f463 00500e93 00325463 00600e93 // bgeu taken, skipped, bge taken, skipped
00c00f6f 00700e93 00800e93 015f0fe7 // jal x30, two skipped, jalr x31
00900e93 00a00e93 00500013 01f00eb3 // two skipped, addi x0, add x29 with x0
0000006f                            // jal to self
ffffffff
00 00000000 01 12345000 // reset bubble, lui
01 12345678 02 00001008
03 fffffffb 04 00000001
05 00000000 06 fffffffd
07 0000000f 08 23456780
09 edcba987 0a 000000f0
0b 00000078 0c 12345673
0d fffffffb 0e 00000001
0f 00000001 10 00008000
11 fffffffd 12 7ffffffd
13 ffffffff 14 000000f8
15 00000078 16 12345678 // and, lw
17 12345679 18 ffffff87
19 00000087 1a fffffffb
1b 0000fffb 1c 0000fff6
00 00000000 00 00000000 // flush bubbles after beq, blt
00 00000000 00 00000000 // after bgeu, bge
1e 000000b4 00 00000000 // jal link
1f 000000c0 00 00000000 // jalr link
00 00000005 1d 000000c0 // write to x0, then x0 reads as zero
00 000000d4 00 00000000 // first pass of the final loop
ffffffff

// File: bench/cpu_core_tb.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_core_tb
    import cpu_pkg::*;
();

    localparam int data_depth = 256;
    localparam int file_words = 512;
    localparam int reset_cycles = 4;
    localparam int timeout_cycles = 2000;
    localparam logic [31:0] end_mark = 32'hffff_ffff;

    logic clk;
    logic reset;
    logic [xlen-1:0] instr_addr;
    logic [xlen-1:0] instr_data;
    logic wb_write;
    logic [reg_addr_w-1:0] wb_addr;
    logic [xlen-1:0] wb_data;

    logic [31:0] file_data [file_words];  // Program, then expected pairs
    int prog_len;
    int exp_base;
    int exp_count;
    int retired;
    int mismatches;
    int timeouts;
    int setup_errors;

    cpu_core #(
        .data_depth(data_depth)
    ) cpu_core_inst (
        .clk        (clk),
        .reset      (reset),
        .instr_addr (instr_addr),
        .instr_data (instr_data),
        .wb_write   (wb_write),
        .wb_addr    (wb_addr),
        .wb_data    (wb_data)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic load_program();
        int i;
        for (i = 0; i < file_words; i++)
            file_data[i] = end_mark;
        $readmemh("bench/program_input.txt", file_data);
        prog_len = 0;
        while (prog_len < file_words && file_data[prog_len] != end_mark)
            prog_len++;
        exp_base = prog_len + 1;  // Skip the separator
        exp_count = 0;
        while (exp_base + 2 * exp_count + 1 < file_words &&
               file_data[exp_base + 2 * exp_count] != end_mark)
            exp_count++;
    endtask

    // Past the program the ROM answers with NOPs
    function automatic logic [31:0] rom_word(input logic [xlen-1:0] addr);
        int idx;
        idx = int'(addr >> 2);
        if (idx < prog_len)
            return file_data[idx];
        return nop_inst;
    endfunction

    task automatic check_retire();
        logic [31:0] exp_addr;
        logic [31:0] exp_data;
        exp_addr = file_data[exp_base + 2 * retired];
        exp_data = file_data[exp_base + 2 * retired + 1];
        assert (wb_addr == exp_addr[reg_addr_w-1:0])
            else begin
                $display("** Error: wb_addr at retire %0d expected %h actual %h",
                         retired, exp_addr[reg_addr_w-1:0], wb_addr);
                mismatches++;
            end
        assert (wb_data == exp_data)
            else begin
                $display("** Error: wb_data at retire %0d expected %h actual %h",
                         retired, exp_data, wb_data);
                mismatches++;
            end
        retired++;
    endtask

    always @(negedge clk)
        instr_data <= rom_word(instr_addr);

    always @(posedge clk) begin
        if (!reset && wb_write && retired < exp_count)
            check_retire();
    end

    initial begin
        int cycles;
        reset = 1'b1;
        instr_data = nop_inst;
        retired = 0;
        mismatches = 0;
        timeouts = 0;
        setup_errors = 0;
        load_program();
        if (prog_len == 0 || exp_count == 0) begin
            $display("Program file gave %0d words and %0d expected retirements",
                     prog_len, exp_count);
            setup_errors++;
        end

        repeat (reset_cycles) begin
            @(negedge clk);
            assert (wb_write == 1'b0)
                else begin
                    $display("** Error: wb_write during reset expected %h actual %h",
                             1'b0, wb_write);
                    mismatches++;
                end
        end
        reset = 1'b0;

        cycles = 0;
        while (retired < exp_count && cycles < timeout_cycles) begin
            @(negedge clk);
            cycles++;
        end
        if (retired < exp_count) begin
            $display("Timed out after %0d cycles with %0d of %0d retirements seen",
                     cycles, retired, exp_count);
            timeouts++;
        end

        $display("Retired %0d of %0d: %0d mismatches, %0d timeouts, %0d setup errors",
                 retired, exp_count, mismatches, timeouts, setup_errors);
        if (mismatches == 0 && timeouts == 0 && setup_errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: source/cpu_core.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_core
    import cpu_pkg::*;
#(
    parameter int data_depth = 256
) (
    input  wire                   clk,
    input  wire                   reset,
    output logic [xlen-1:0]       instr_addr,
    input  wire [xlen-1:0]        instr_data,
    output logic                  wb_write,
    output logic [reg_addr_w-1:0] wb_addr,
    output logic [xlen-1:0]       wb_data
);

    // IF to ID
    logic [xlen-1:0] pc_id, inst_id;
    logic stall_id;

    // Decode to register file and EX
    logic read1, read2, write, br;
    logic [reg_addr_w-1:0] reg1_addr, reg2_addr, regw_addr;
    logic [xlen-1:0] reg1_data, reg2_data;
    alu_sel_e alusel;
    logic [alu_op_w-1:0] aluop;
    logic [xlen-1:0] op1, op2, link_addr, mem_offset, br_addr, br_offset;

    // EX outputs
    logic br_taken, ex_load, ex_write, ex_mem_en;
    logic [xlen-1:0] br_target, ex_regw_data, ex_result, ex_store_data;
    logic [reg_addr_w-1:0] ex_regw_addr;
    logic [alu_op_w-1:0] ex_mem_op;

    // MEM forward path
    logic mem_write;
    logic [reg_addr_w-1:0] mem_regw_addr;
    logic [xlen-1:0] mem_regw_data;

    stage_if stage_if_inst (.*);

    stage_id stage_id_inst (
        .pc   (pc_id),
        .inst (inst_id),
        .*
    );

    stage_ex stage_ex_inst (.*);

    stage_mem #(
        .data_depth(data_depth)
    ) stage_mem_inst (.*);

    reg_file reg_file_inst (.*);

endmodule

`default_nettype wire

// File: source/stage_mem.sv
`timescale 1ns/1ps
`default_nettype none

module stage_mem
    import cpu_pkg::*;
#(
    parameter int data_depth = 256
) (
    input  wire                   clk,
    input  wire                   reset,
    input  wire                   ex_write,
    input  wire [reg_addr_w-1:0]  ex_regw_addr,
    input  wire [xlen-1:0]        ex_result,
    input  wire [xlen-1:0]        ex_store_data,
    input  wire [alu_op_w-1:0]    ex_mem_op,
    input  wire                   ex_mem_en,
    output logic                  mem_write,
    output logic [reg_addr_w-1:0] mem_regw_addr,
    output logic [xlen-1:0]       mem_regw_data,
    output logic                  wb_write,
    output logic [reg_addr_w-1:0] wb_addr,
    output logic [xlen-1:0]       wb_data
);

    localparam int idx_w = $clog2(data_depth);

    logic [xlen-1:0] ram [data_depth];
    logic write_q, en_q;
    logic [reg_addr_w-1:0] rd_q;
    logic [xlen-1:0] addr_q, store_q;
    logic [alu_op_w-1:0] op_q;
    logic [idx_w-1:0] idx;
    logic [xlen-1:0] word, load_data;
    logic [7:0] lane_byte;
    logic [15:0] lane_half;

    always_ff @(posedge clk) begin
        if (reset) begin
            write_q <= 1'b0;
            en_q <= 1'b0;
        end else begin
            write_q <= ex_write;
            en_q <= ex_mem_en;
        end
    end

    always_ff @(posedge clk) begin
        rd_q <= ex_regw_addr;
        addr_q <= ex_result;
        store_q <= ex_store_data;
        op_q <= ex_mem_op;
    end

    assign idx = addr_q[idx_w+1:2];
    assign word = ram[idx];
    assign lane_byte = word[{addr_q[1:0], 3'b000} +: 8];
    assign lane_half = addr_q[1] ? word[31:16] : word[15:0];

    always_comb begin
        case (op_q)
            4'd0: load_data = {{24{lane_byte[7]}}, lane_byte};  // LB
            4'd1: load_data = {{16{lane_half[15]}}, lane_half};  // LH
            4'd3: load_data = {24'b0, lane_byte};
            4'd4: load_data = {16'b0, lane_half};
            default: load_data = word;
        endcase
    end

    always_ff @(posedge clk) begin
        if (en_q) begin
            case (op_q)
                4'd5: ram[idx][{addr_q[1:0], 3'b000} +: 8] <= store_q[7:0];
                4'd6: ram[idx][{addr_q[1], 4'b0000} +: 16] <= store_q[15:0];
                4'd7: ram[idx] <= store_q;
                default: ;
            endcase
        end
    end

    assign mem_write = write_q;
    assign mem_regw_addr = rd_q;
    assign mem_regw_data = en_q ? load_data : addr_q;

    always_ff @(posedge clk) begin
        if (reset)
            wb_write <= 1'b0;
        else
            wb_write <= write_q;
    end

    always_ff @(posedge clk) begin
        wb_addr <= rd_q;
        wb_data <= mem_regw_data;
    end

    assert property (@(posedge clk) disable iff (reset) en_q |-> addr_q < data_depth * 4)
        else $error("data access out of range: %h", addr_q);

endmodule

`default_nettype wire

// File: source/stage_ex.sv
`timescale 1ns/1ps
`default_nettype none

module stage_ex
    import cpu_pkg::*;
(
    input  wire                   clk,
    input  wire                   reset,
    input  wire                   stall_id,
    input  wire alu_sel_e         alusel,
    input  wire [alu_op_w-1:0]    aluop,
    input  wire [xlen-1:0]        op1,
    input  wire [xlen-1:0]        op2,
    input  wire [xlen-1:0]        link_addr,
    input  wire                   write,
    input  wire [reg_addr_w-1:0]  regw_addr,
    input  wire [xlen-1:0]        mem_offset,
    input  wire                   br,
    input  wire [xlen-1:0]        br_addr,
    input  wire [xlen-1:0]        br_offset,
    output logic                  br_taken,
    output logic [xlen-1:0]       br_target,
    output logic                  ex_load,
    output logic                  ex_write,
    output logic [reg_addr_w-1:0] ex_regw_addr,
    output logic [xlen-1:0]       ex_regw_data,
    output logic [xlen-1:0]       ex_result,
    output logic [xlen-1:0]       ex_store_data,
    output logic [alu_op_w-1:0]   ex_mem_op,
    output logic                  ex_mem_en
);

    alu_sel_e sel_q;
    logic write_q, br_q;
    logic [alu_op_w-1:0] op_q;
    logic [reg_addr_w-1:0] rd_q;
    logic [xlen-1:0] a_q, b_q, link_q, offset_q, br_addr_q, br_offset_q;
    logic [xlen-1:0] result, target;
    logic cond;

    always_ff @(posedge clk) begin
        if (reset || stall_id || br_taken) begin
            sel_q <= sel_nop;  // Bubble
            write_q <= 1'b0;
            br_q <= 1'b0;
        end else begin
            sel_q <= alusel;
            write_q <= write;
            br_q <= br;
        end
    end

    always_ff @(posedge clk) begin
        op_q <= aluop;
        rd_q <= regw_addr;
        a_q <= op1;
        b_q <= op2;
        link_q <= link_addr;
        offset_q <= mem_offset;
        br_addr_q <= br_addr;
        br_offset_q <= br_offset;
    end

    always_comb begin
        result = '0;
        cond = 1'b0;
        case (sel_q)
            sel_logic: begin
                case (op_q)
                    4'd0: result = a_q | b_q;
                    4'd1: result = a_q & b_q;
                    default: result = a_q ^ b_q;
                endcase
            end
            sel_shift: begin
                case (op_q)
                    4'd0: result = a_q << b_q[4:0];
                    4'd1: result = a_q >> b_q[4:0];
                    default: result = $signed(a_q) >>> b_q[4:0];
                endcase
            end
            sel_arith: begin
                case (op_q)
                    4'd0: result = a_q + b_q;
                    4'd1: result = a_q - b_q;
                    4'd2: result = {31'b0, $signed(a_q) < $signed(b_q)};
                    default: result = {31'b0, a_q < b_q};
                endcase
            end
            sel_branch: begin
                case (op_q)
                    4'd0: cond = a_q == b_q;
                    4'd1: cond = a_q != b_q;
                    4'd2: cond = $signed(a_q) < $signed(b_q);
                    4'd3: cond = $signed(a_q) >= $signed(b_q);
                    4'd4: cond = a_q < b_q;
                    default: cond = a_q >= b_q;
                endcase
            end
            sel_jump: begin
                result = link_q + 32'd4;
                cond = 1'b1;
            end
            sel_mem: result = a_q + offset_q;  // Effective address
            default: ;
        endcase
    end

    assign target = br_addr_q + br_offset_q;
    assign br_target = {target[xlen-1:1], 1'b0};  // Bit 0 dropped for JALR
    assign br_taken = br_q && cond;

    assign ex_load = (sel_q == sel_mem) && (op_q < 4'd5);
    assign ex_write = write_q;
    assign ex_regw_addr = rd_q;
    assign ex_regw_data = result;
    assign ex_result = result;
    assign ex_store_data = b_q;
    assign ex_mem_op = op_q;
    assign ex_mem_en = (sel_q == sel_mem);

    // A stalled or flushed slot enters EX as a bubble
    assert property (@(posedge clk) disable iff (reset)
                     (stall_id || br_taken) |=> !br_taken)
        else $error("redirect raised from a bubble");

endmodule

`default_nettype wire

// File: source/stage_id.sv
`timescale 1ns/1ps
`default_nettype none

module stage_id
    import cpu_pkg::*;
(
    input  wire                   reset,
    output logic                  stall_id,
    input  wire [xlen-1:0]        pc,
    input  wire [xlen-1:0]        inst,
    output logic                  read1,
    output logic [reg_addr_w-1:0] reg1_addr,
    input  wire [xlen-1:0]        reg1_data,
    output logic                  read2,
    output logic [reg_addr_w-1:0] reg2_addr,
    input  wire [xlen-1:0]        reg2_data,
    output alu_sel_e              alusel,
    output logic [alu_op_w-1:0]   aluop,
    output logic [xlen-1:0]       op1,
    output logic [xlen-1:0]       op2,
    output logic [xlen-1:0]       link_addr,
    output logic                  write,
    output logic [reg_addr_w-1:0] regw_addr,
    output logic [xlen-1:0]       mem_offset,
    output logic                  br,
    output logic [xlen-1:0]       br_addr,
    output logic [xlen-1:0]       br_offset,
    input  wire                   ex_load,
    input  wire                   ex_write,
    input  wire [reg_addr_w-1:0]  ex_regw_addr,
    input  wire [xlen-1:0]        ex_regw_data,
    input  wire                   mem_write,
    input  wire [reg_addr_w-1:0]  mem_regw_addr,
    input  wire [xlen-1:0]        mem_regw_data
);

    wire [2:0] funct3 = inst[14:12];
    wire [6:0] funct7 = inst[31:25];
    wire [xlen-1:0] i_imm = {{20{inst[31]}}, inst[31:20]};
    wire [xlen-1:0] s_imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    wire [xlen-1:0] b_imm = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
    wire [xlen-1:0] u_imm = {inst[31:12], 12'b0};
    wire [xlen-1:0] j_imm = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};

    opcode_e opcode;
    logic [xlen-1:0] imm1, imm2;
    logic stall1, stall2;

    assign opcode = opcode_e'(inst[6:0]);

    always_comb begin
        alusel = sel_nop;
        aluop = '0;
        read1 = 1'b0;
        reg1_addr = inst[19:15];
        read2 = 1'b0;
        reg2_addr = inst[24:20];
        imm1 = '0;
        imm2 = '0;
        write = 1'b0;
        regw_addr = inst[11:7];
        mem_offset = '0;
        br = 1'b0;
        br_offset = '0;
        link_addr = pc;
        case (opcode)
            op_lui: begin
                alusel = sel_arith;
                imm1 = u_imm;
                write = 1'b1;
            end
            op_auipc: begin
                alusel = sel_arith;
                imm1 = u_imm;
                imm2 = pc;
                write = 1'b1;
            end
            op_jal, op_jalr: begin
                alusel = sel_jump;
                read1 = (opcode == op_jalr);
                write = 1'b1;
                br = 1'b1;
                br_offset = (opcode == op_jalr) ? i_imm : j_imm;
            end
            op_branch: begin
                alusel = sel_branch;
                aluop = {1'b0, funct3[2] ? funct3 - 3'd2 : funct3};  // BEQ..BGEU as 0..5
                read1 = 1'b1;
                read2 = 1'b1;
                br = 1'b1;
                br_offset = b_imm;
            end
            op_load: begin
                alusel = sel_mem;
                aluop = {1'b0, funct3[2] ? funct3 - 3'd1 : funct3};  // LBU, LHU land on 3, 4
                read1 = 1'b1;
                write = 1'b1;
                mem_offset = i_imm;
            end
            op_store: begin
                alusel = sel_mem;
                aluop = 4'd5 + {2'b00, funct3[1:0]};  // SB SH SW
                read1 = 1'b1;
                read2 = 1'b1;
                mem_offset = s_imm;
            end
            op_op_imm, op_op: begin
                read1 = 1'b1;
                read2 = (opcode == op_op);
                imm2 = i_imm;
                write = 1'b1;
                case (funct3)
                    3'b000, 3'b010, 3'b011: alusel = sel_arith;
                    3'b001, 3'b101: alusel = sel_shift;
                    default: alusel = sel_logic;
                endcase
                case (funct3)
                    3'b000: aluop = {3'b000, opcode == op_op && funct7[5]};  // ADD or SUB
                    3'b010: aluop = 4'd2;                   // SLT
                    3'b011: aluop = 4'd3;                   // SLTU
                    3'b100: aluop = 4'd2;                   // XOR
                    3'b101: aluop = funct7[5] ? 4'd2 : 4'd1;  // SRA or SRL
                    3'b111: aluop = 4'd1;                   // AND
                    default: aluop = 4'd0;                  // SLL, OR
                endcase
            end
            default: ;  // Anything else flows on as a bubble
        endcase
    end

    // Returns {stall, value}
    function automatic logic [xlen:0] select_operand(
        input logic                  rd_en,
        input logic [reg_addr_w-1:0] addr,
        input logic [xlen-1:0]       imm,
        input logic [xlen-1:0]       rf_data
    );
        if (!rd_en)
            return {1'b0, imm};
        if (addr == '0)
            return '0;
        if (ex_load && ex_regw_addr == addr)
            return {1'b1, {xlen{1'b0}}};  // Load data not back yet
        if (ex_write && ex_regw_addr == addr)
            return {1'b0, ex_regw_data};
        if (mem_write && mem_regw_addr == addr)
            return {1'b0, mem_regw_data};
        return {1'b0, rf_data};
    endfunction

    always_comb begin
        {stall1, op1} = select_operand(read1, reg1_addr, imm1, reg1_data);
        {stall2, op2} = select_operand(read2, reg2_addr, imm2, reg2_data);
    end

    assign stall_id = stall1 | stall2;
    assign br_addr = (opcode == op_jalr) ? op1 : pc;

endmodule

`default_nettype wire

// File: source/stage_if.sv
`timescale 1ns/1ps
`default_nettype none

module stage_if
    import cpu_pkg::*;
(
    input  wire              clk,
    input  wire              reset,
    input  wire              stall_id,
    input  wire              br_taken,
    input  wire [xlen-1:0]   br_target,
    output logic [xlen-1:0]  instr_addr,
    input  wire [xlen-1:0]   instr_data,
    output logic [xlen-1:0]  pc_id,
    output logic [xlen-1:0]  inst_id
);

    logic [xlen-1:0] pc;

    assign instr_addr = pc;  // ROM answers in the same cycle

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= '0;
            pc_id <= '0;
            inst_id <= nop_inst;
        end else if (br_taken) begin
            pc <= br_target;
            inst_id <= nop_inst;  // Kill the wrong-path fetch
        end else if (!stall_id) begin
            pc <= pc + 32'd4;
            pc_id <= pc;
            inst_id <= instr_data;
        end
    end

    assert property (@(posedge clk) disable iff (reset) pc[1:0] == 2'b00)
        else $error("pc lost word alignment: %h", pc);

endmodule

`default_nettype wire

// File: source/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file
    import cpu_pkg::*;
(
    input  wire                   clk,
    input  wire                   reset,
    input  wire                   read1,
    input  wire [reg_addr_w-1:0]  reg1_addr,
    output logic [xlen-1:0]       reg1_data,
    input  wire                   read2,
    input  wire [reg_addr_w-1:0]  reg2_addr,
    output logic [xlen-1:0]       reg2_data,
    input  wire                   wb_write,
    input  wire [reg_addr_w-1:0]  wb_addr,
    input  wire [xlen-1:0]        wb_data
);

    logic [xlen-1:0] regs [32];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++)
                regs[i] <= '0;
        end else if (wb_write && wb_addr != '0) begin
            regs[wb_addr] <= wb_data;
        end
    end

    // Same-cycle write wins over the stored value
    assign reg1_data = (!read1 || reg1_addr == '0) ? '0 :
                       (wb_write && wb_addr == reg1_addr) ? wb_data : regs[reg1_addr];
    assign reg2_data = (!read2 || reg2_addr == '0) ? '0 :
                       (wb_write && wb_addr == reg2_addr) ? wb_data : regs[reg2_addr];

    assert property (@(posedge clk) disable iff (reset) wb_write |-> !$isunknown(wb_data))
        else $error("unknown data retired to x%0d", wb_addr);

endmodule

`default_nettype wire

// File: source/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

    localparam int xlen = 32;
    localparam int reg_addr_w = 5;
    localparam int alu_op_w = 4;

    // Execution unit picked in EX
    typedef enum logic [2:0] {
        sel_nop    = 3'b000,
        sel_logic  = 3'b001,
        sel_shift  = 3'b010,
        sel_arith  = 3'b100,
        sel_branch = 3'b101,
        sel_jump   = 3'b110,
        sel_mem    = 3'b111
    } alu_sel_e;

    typedef enum logic [6:0] {
        op_lui    = 7'b0110111,
        op_auipc  = 7'b0010111,
        op_jal    = 7'b1101111,
        op_jalr   = 7'b1100111,
        op_branch = 7'b1100011,
        op_load   = 7'b0000011,
        op_store  = 7'b0100011,
        op_op_imm = 7'b0010011,
        op_op     = 7'b0110011
    } opcode_e;

    localparam logic [xlen-1:0] nop_inst = 32'h0000_0013;  // ADDI x0, x0, 0

endpackage

`default_nettype wire
